//--- flist.f
src/core_pkg.sv
src/isa_pkg.sv
src/id_ex_if.sv
src/decode_stage.sv
src/id_to_ex.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/core_top.sv
sim/tb_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_core -f flist.f -o tb_core \
  && ./obj_dir/tb_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim/core_patterns.txt
// I <instruction word, hex>          program order, pc starts at 0
// E <rd, hex> <writeback data, hex>  retirement order
I 00700093  // addi x1, x0, 7
I FFD00113  // addi x2, x0, -3
I 123451B7  // lui x3, 0x12345
I 00001217  // auipc x4, 0x1 at pc 12
I 402082B3  // sub x5, x1, x2
I 00112333  // slt x6, x2, x1
I 006093B3  // sll x7, x1, x6
I 00415413  // srli x8, x2, 4
I 0083C4B3  // xor x9, x7, x8
I 0034E533  // or x10, x9, x3
I 0F057593  // andi x11, x10, 0xf0
I 00A02423  // sw x10, 8(x0)
I 00802603  // lw x12, 8(x0)
I 001606B3  // add x13, x12, x1
I 00508013  // addi x0, x1, 5
I 00D00733  // add x14, x0, x13
E 01 00000007
E 02 FFFFFFFD
E 03 12345000
E 04 0000100C
E 05 0000000A
E 06 00000001
E 07 0000000E
E 08 0FFFFFFF
E 09 0FFFFFF1
E 0A 1FFFFFF1
E 0B 000000F0
E 0C 1FFFFFF1
E 0D 1FFFFFF8
E 0E 1FFFFFF8

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  localparam int CLK_PERIOD = 100;

  logic        clk;
  logic        rst_n_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_ready_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  logic [31:0] instrs [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          n_exp = 0;
  int          exp_idx = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          low_cycles = 0;
  bit          loaded = 1'b0;

  core_top #(
    .DMEM_WORDS (16)
  ) u_core_top (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // helpers
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic read_patterns();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("sim/core_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file sim/core_patterns.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.substr(0, 0) == "I") begin
        cnt = $sscanf(line.substr(1, line.len() - 1), "%h", a);
        if (cnt == 1) begin
          instrs.push_back(a);
        end else begin
          $display("an instruction record in the pattern file cannot be read");
          other_errors++;
        end
      end else if (line.substr(0, 0) == "E") begin
        cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        if (cnt == 2) begin
          exp_rd.push_back(a[4:0]);
          exp_data.push_back(b);
        end else begin
          $display("an expected writeback record in the pattern file cannot be read");
          other_errors++;
        end
      end
    end
    $fclose(fd);
    n_exp = exp_rd.size();
  endtask

  // true when the instruction word uses register r as a source
  function automatic bit reads_reg(logic [31:0] w, logic [4:0] r);
    case (w[6:0])
      7'b0110011, 7'b0100011: return (w[19:15] == r) || (w[24:20] == r);
      7'b0010011, 7'b0000011: return w[19:15] == r;
      default:                return 1'b0;
    endcase
  endfunction

  // a load directly followed by a reader of its rd costs one cycle of ready low
  function automatic int count_load_use();
    int n;
    n = 0;
    for (int i = 0; i + 1 < instrs.size(); i++) begin
      if (instrs[i][6:0] == 7'b0000011 && instrs[i][11:7] != 5'd0 &&
          reads_reg(instrs[i + 1], instrs[i][11:7]))
        n++;
    end
    return n;
  endfunction

  // --------------------
  // stimulus and end of run
  initial begin
    int idx;
    int exp_low;
    bit prev_low;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    read_patterns();
    if (instrs.size() == 0 || n_exp == 0) begin
      $display("pattern file holds no instruction or no expected writeback");
      other_errors++;
    end
    exp_low = count_load_use();
    loaded  = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n_i  = 1'b1;
    prev_low = 1'b0;
    idx      = 0;
    while (idx < instrs.size()) begin
      instr_valid_i = 1'b1;
      instr_i       = instrs[idx];
      // ready depends on pipeline state only and so decides the coming edge
      if (instr_ready_o) begin
        idx++;
        prev_low = 1'b0;
      end else begin
        low_cycles++;
        if (prev_low) begin
          $display("instr_ready_o stayed low for more than one cycle at %0t", $time);
          other_errors++;
        end
        prev_low = 1'b1;
      end
      @(negedge clk);
    end
    instr_valid_i = 1'b0;
    instr_i       = '0;
    wait (exp_idx >= n_exp);
    // a few more cycles so that an extra writeback still shows up
    repeat (6) @(negedge clk);
    check_value("cycles with instr_ready_o low", low_cycles, exp_low);
    $display("errors: %0d mismatches, %0d other, %0d of %0d writebacks checked",
             mismatches, other_errors, exp_idx, n_exp);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // --------------------
  // writeback monitor
  always @(negedge clk) begin
    if (rst_n_i && wb_valid_o) begin
      if (exp_idx < n_exp) begin
        check_value($sformatf("rd of writeback %0d", exp_idx),
                    {27'd0, wb_rd_o}, {27'd0, exp_rd[exp_idx]});
        check_value($sformatf("data of writeback %0d", exp_idx),
                    wb_data_o, exp_data[exp_idx]);
        exp_idx++;
      end else begin
        $display("unexpected extra writeback to x%0d with data %h at %0t",
                 wb_rd_o, wb_data_o, $time);
        other_errors++;
      end
    end
  end

  // the watchdog time scales with the program length
  initial begin
    wait (loaded);
    #((instrs.size() + 20) * CLK_PERIOD * 2);
    $display("timeout: only %0d of %0d expected writebacks arrived", exp_idx, n_exp);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- src/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // --------------------
  // execute controls
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  // where operand A of the ALU comes from
  typedef enum logic [1:0] {
    OPA_REG,
    OPA_PC,
    OPA_ZERO
  } opa_sel_e;

  // --------------------
  // operand forwarding
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_e;

endpackage

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter int DMEM_WORDS = 16
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  core_pkg::word_t    instr_i,
  output logic               instr_ready_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::word_t    wb_data_o
);

  // --------------------
  // ID/EX outputs
  core_pkg::word_t    ex_pc;
  core_pkg::word_t    ex_rs1_data;
  core_pkg::word_t    ex_rs2_data;
  core_pkg::word_t    ex_imm;
  core_pkg::reg_idx_t ex_rd;
  core_pkg::reg_idx_t ex_rs1;
  core_pkg::reg_idx_t ex_rs2;
  core_pkg::alu_op_e  ex_alu_op;
  core_pkg::opa_sel_e ex_opa_sel;
  logic               ex_imm_sel;
  logic               ex_write_en;
  logic               ex_load;
  logic               ex_store;

  // EX/MEM outputs
  core_pkg::word_t    mem_alu_result;
  core_pkg::word_t    mem_store_data;
  core_pkg::reg_idx_t mem_rd;
  logic               mem_write_en;
  logic               mem_load;
  logic               mem_store;

  // hazard control
  core_pkg::fwd_sel_e fwd_a;
  core_pkg::fwd_sel_e fwd_b;
  logic               stall;
  logic               clear;

  id_ex_if id_ex ();

  decode_stage u_decode_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall),
    .wb_en_i       (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .instr_ready_o (instr_ready_o),
    .id_ex         (id_ex)
  );

  // only decode holds on a load-use, the ID/EX slot takes a bubble
  id_to_ex u_id_to_ex (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (1'b0),
    .clear_i      (clear),
    .id_ex        (id_ex),
    .fwd_a_i      (fwd_a),
    .fwd_b_i      (fwd_b),
    .fwd_ex_mem_i (mem_alu_result),
    .fwd_mem_wb_i (wb_data_o),
    .pc_o         (ex_pc),
    .rs1_data_o   (ex_rs1_data),
    .rs2_data_o   (ex_rs2_data),
    .imm_o        (ex_imm),
    .rd_o         (ex_rd),
    .rs1_o        (ex_rs1),
    .rs2_o        (ex_rs2),
    .alu_op_o     (ex_alu_op),
    .opa_sel_o    (ex_opa_sel),
    .imm_sel_o    (ex_imm_sel),
    .write_en_o   (ex_write_en),
    .load_o       (ex_load),
    .store_o      (ex_store)
  );

  hazard_unit u_hazard_unit (
    .id_rs1_i       (id_ex.rs1),
    .id_rs2_i       (id_ex.rs2),
    .ex_rd_i        (ex_rd),
    .ex_load_i      (ex_load),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .mem_rd_i       (mem_rd),
    .mem_write_en_i (mem_write_en),
    .mem_load_i     (mem_load),
    .wb_rd_i        (wb_rd_o),
    .wb_write_en_i  (wb_valid_o),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .stall_o        (stall),
    .clear_o        (clear)
  );

  execute_stage u_execute_stage (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .pc_i             (ex_pc),
    .rs1_data_i       (ex_rs1_data),
    .rs2_data_i       (ex_rs2_data),
    .imm_i            (ex_imm),
    .rd_i             (ex_rd),
    .alu_op_i         (ex_alu_op),
    .opa_sel_i        (ex_opa_sel),
    .imm_sel_i        (ex_imm_sel),
    .write_en_i       (ex_write_en),
    .load_i           (ex_load),
    .store_i          (ex_store),
    .mem_alu_result_o (mem_alu_result),
    .mem_store_data_o (mem_store_data),
    .mem_rd_o         (mem_rd),
    .mem_write_en_o   (mem_write_en),
    .mem_load_o       (mem_load),
    .mem_store_o      (mem_store)
  );

  mem_wb_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_mem_wb_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .alu_result_i (mem_alu_result),
    .store_data_i (mem_store_data),
    .rd_i         (mem_rd),
    .write_en_i   (mem_write_en),
    .load_i       (mem_load),
    .store_i      (mem_store),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  core_pkg::word_t    instr_i,
  input  logic               stall_i,
  input  logic               wb_en_i,
  input  core_pkg::reg_idx_t wb_rd_i,
  input  core_pkg::word_t    wb_data_i,
  output logic               instr_ready_o,
  id_ex_if.producer          id_ex
);

  core_pkg::word_t    pc_cnt_q;
  core_pkg::word_t    pc_q;
  core_pkg::word_t    instr_q;
  logic               valid_q;
  logic               accept;
  logic               use_rs1;
  logic               use_rs2;
  core_pkg::reg_idx_t rs1_idx;
  core_pkg::reg_idx_t rs2_idx;
  core_pkg::word_t    imm_i_type;
  core_pkg::word_t    imm_s_type;
  core_pkg::word_t    imm_u_type;
  core_pkg::word_t    regs [32];

  function automatic core_pkg::alu_op_e alu_op_of(logic [2:0] funct3, logic sub);
    case (funct3)
      isa_pkg::F3_ADD_SUB: return sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     return core_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     return core_pkg::ALU_SLT;
      isa_pkg::F3_XOR:     return core_pkg::ALU_XOR;
      isa_pkg::F3_SRL:     return core_pkg::ALU_SRL;
      isa_pkg::F3_OR:      return core_pkg::ALU_OR;
      default:             return core_pkg::ALU_AND;
    endcase
  endfunction

  // --------------------
  // IF/ID register and program counter
  assign instr_ready_o = ~stall_i;
  assign accept        = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      pc_cnt_q <= '0;
    end else if (accept) begin
      valid_q  <= 1'b1;
      pc_cnt_q <= pc_cnt_q + 32'd4;
    end else if (!stall_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= instr_i;
      pc_q    <= pc_cnt_q;
    end
  end

  // --------------------
  // register file, write first so a retiring value is seen by decode
  always_ff @(posedge clk) begin
    if (wb_en_i) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // unused sources read as x0 so they never trigger a forward or a stall
  assign rs1_idx = use_rs1 ? instr_q[isa_pkg::RS1_LSB +: 5] : '0;
  assign rs2_idx = use_rs2 ? instr_q[isa_pkg::RS2_LSB +: 5] : '0;

  assign id_ex.rs1_data = (rs1_idx == '0) ? '0 :
                          (wb_en_i && wb_rd_i == rs1_idx) ? wb_data_i : regs[rs1_idx];
  assign id_ex.rs2_data = (rs2_idx == '0) ? '0 :
                          (wb_en_i && wb_rd_i == rs2_idx) ? wb_data_i : regs[rs2_idx];

  // --------------------
  // instruction decoder
  assign imm_i_type = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s_type = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_u_type = {instr_q[31:12], 12'b0};

  always_comb begin
    id_ex.alu_op   = core_pkg::ALU_ADD;
    id_ex.opa_sel  = core_pkg::OPA_REG;
    id_ex.imm_sel  = 1'b1;
    id_ex.imm      = imm_i_type;
    id_ex.write_en = 1'b0;
    id_ex.load     = 1'b0;
    id_ex.store    = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    if (valid_q) begin
      case (isa_pkg::opcode_e'(instr_q[6:0]))
        isa_pkg::OPC_OP: begin
          id_ex.alu_op   = alu_op_of(instr_q[isa_pkg::F3_LSB +: 3],
                                     instr_q[isa_pkg::F7_LSB +: 7] == isa_pkg::F7_SUB);
          id_ex.imm_sel  = 1'b0;
          id_ex.write_en = 1'b1;
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
        end
        isa_pkg::OPC_OP_IMM: begin
          id_ex.alu_op   = alu_op_of(instr_q[isa_pkg::F3_LSB +: 3], 1'b0);
          id_ex.write_en = 1'b1;
          use_rs1        = 1'b1;
        end
        isa_pkg::OPC_LUI: begin
          id_ex.alu_op   = core_pkg::ALU_PASS_B;
          id_ex.opa_sel  = core_pkg::OPA_ZERO;
          id_ex.imm      = imm_u_type;
          id_ex.write_en = 1'b1;
        end
        isa_pkg::OPC_AUIPC: begin
          id_ex.opa_sel  = core_pkg::OPA_PC;
          id_ex.imm      = imm_u_type;
          id_ex.write_en = 1'b1;
        end
        isa_pkg::OPC_LOAD: begin
          id_ex.write_en = 1'b1;
          id_ex.load     = 1'b1;
          use_rs1        = 1'b1;
        end
        isa_pkg::OPC_STORE: begin
          id_ex.imm   = imm_s_type;
          id_ex.store = 1'b1;
          use_rs1     = 1'b1;
          use_rs2     = 1'b1;
        end
        default: begin
          // anything outside the subset retires as a bubble
          id_ex.write_en = 1'b0;
        end
      endcase
    end
  end

  assign id_ex.pc    = pc_q;
  assign id_ex.instr = instr_q;
  assign id_ex.rd    = instr_q[isa_pkg::RD_LSB +: 5];
  assign id_ex.rs1   = rs1_idx;
  assign id_ex.rs2   = rs2_idx;

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  core_pkg::word_t    pc_i,
  input  core_pkg::word_t    rs1_data_i,
  input  core_pkg::word_t    rs2_data_i,
  input  core_pkg::word_t    imm_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::alu_op_e  alu_op_i,
  input  core_pkg::opa_sel_e opa_sel_i,
  input  logic               imm_sel_i,
  input  logic               write_en_i,
  input  logic               load_i,
  input  logic               store_i,
  output core_pkg::word_t    mem_alu_result_o,
  output core_pkg::word_t    mem_store_data_o,
  output core_pkg::reg_idx_t mem_rd_o,
  output logic               mem_write_en_o,
  output logic               mem_load_o,
  output logic               mem_store_o
);

  core_pkg::word_t op_a;
  core_pkg::word_t op_b;
  core_pkg::word_t alu_res;

  // --------------------
  // operand select and ALU
  always_comb begin
    case (opa_sel_i)
      core_pkg::OPA_PC:   op_a = pc_i;
      core_pkg::OPA_ZERO: op_a = '0;
      default:            op_a = rs1_data_i;
    endcase
  end

  assign op_b = imm_sel_i ? imm_i : rs2_data_i;

  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_SUB:    alu_res = op_a - op_b;
      core_pkg::ALU_AND:    alu_res = op_a & op_b;
      core_pkg::ALU_OR:     alu_res = op_a | op_b;
      core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
      core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
      core_pkg::ALU_PASS_B: alu_res = op_b;
      default:              alu_res = op_a + op_b;
    endcase
  end

  // --------------------
  // EX/MEM register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_write_en_o <= 1'b0;
      mem_load_o     <= 1'b0;
      mem_store_o    <= 1'b0;
    end else begin
      mem_write_en_o <= write_en_i;
      mem_load_o     <= load_i;
      mem_store_o    <= store_i;
    end
  end

  always_ff @(posedge clk) begin
    mem_alu_result_o <= alu_res;
    mem_store_data_o <= rs2_data_i;
    mem_rd_o         <= rd_i;
  end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  core_pkg::reg_idx_t id_rs1_i,
  input  core_pkg::reg_idx_t id_rs2_i,
  input  core_pkg::reg_idx_t ex_rd_i,
  input  logic               ex_load_i,
  input  core_pkg::reg_idx_t ex_rs1_i,
  input  core_pkg::reg_idx_t ex_rs2_i,
  input  core_pkg::reg_idx_t mem_rd_i,
  input  logic               mem_write_en_i,
  input  logic               mem_load_i,
  input  core_pkg::reg_idx_t wb_rd_i,
  input  logic               wb_write_en_i,
  output core_pkg::fwd_sel_e fwd_a_o,
  output core_pkg::fwd_sel_e fwd_b_o,
  output logic               stall_o,
  output logic               clear_o
);

  logic mem_fwd_ok;
  logic wb_fwd_ok;

  function automatic core_pkg::fwd_sel_e pick(core_pkg::reg_idx_t rs,
                                              logic mem_ok, core_pkg::reg_idx_t mem_rd,
                                              logic wb_ok, core_pkg::reg_idx_t wb_rd);
    if (mem_ok && mem_rd == rs)
      return core_pkg::FWD_EX_MEM;
    else if (wb_ok && wb_rd == rs)
      return core_pkg::FWD_MEM_WB;
    return core_pkg::FWD_NONE;
  endfunction

  // load data is not ready in EX/MEM yet, the stall covers that case
  assign mem_fwd_ok = mem_write_en_i & ~mem_load_i & (mem_rd_i != '0);
  assign wb_fwd_ok  = wb_write_en_i & (wb_rd_i != '0);

  assign fwd_a_o = pick(ex_rs1_i, mem_fwd_ok, mem_rd_i, wb_fwd_ok, wb_rd_i);
  assign fwd_b_o = pick(ex_rs2_i, mem_fwd_ok, mem_rd_i, wb_fwd_ok, wb_rd_i);

  // load-use: hold decode one cycle and send a bubble down instead
  assign stall_o = ex_load_i & (ex_rd_i != '0) &
                   ((ex_rd_i == id_rs1_i) | (ex_rd_i == id_rs2_i));
  assign clear_o = stall_o;

endmodule

//--- src/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;
  core_pkg::word_t    pc;
  // raw word, carried along for tracing in waves
  core_pkg::word_t    instr;
  core_pkg::word_t    rs1_data;
  core_pkg::word_t    rs2_data;
  core_pkg::reg_idx_t rd;
  core_pkg::reg_idx_t rs1;
  core_pkg::reg_idx_t rs2;
  core_pkg::word_t    imm;
  core_pkg::alu_op_e  alu_op;
  core_pkg::opa_sel_e opa_sel;
  logic               imm_sel;
  logic               write_en;
  logic               load;
  logic               store;

  modport producer (
    output pc, instr, rs1_data, rs2_data, rd, rs1, rs2, imm,
    output alu_op, opa_sel, imm_sel, write_en, load, store
  );

  modport consumer (
    input pc, instr, rs1_data, rs2_data, rd, rs1, rs2, imm,
    input alu_op, opa_sel, imm_sel, write_en, load, store
  );
endinterface

//--- src/id_to_ex.sv
`timescale 1ns/1ps

module id_to_ex (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stall_i,
  input  logic               clear_i,
  id_ex_if.consumer          id_ex,
  input  core_pkg::fwd_sel_e fwd_a_i,
  input  core_pkg::fwd_sel_e fwd_b_i,
  input  core_pkg::word_t    fwd_ex_mem_i,
  input  core_pkg::word_t    fwd_mem_wb_i,
  output core_pkg::word_t    pc_o,
  output core_pkg::word_t    rs1_data_o,
  output core_pkg::word_t    rs2_data_o,
  output core_pkg::word_t    imm_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::alu_op_e  alu_op_o,
  output core_pkg::opa_sel_e opa_sel_o,
  output logic               imm_sel_o,
  output logic               write_en_o,
  output logic               load_o,
  output logic               store_o
);

  core_pkg::word_t rs1_q;
  core_pkg::word_t rs2_q;

  function automatic core_pkg::word_t fwd_mux(core_pkg::fwd_sel_e sel,
                                              core_pkg::word_t    own,
                                              core_pkg::word_t    ex_mem,
                                              core_pkg::word_t    mem_wb);
    case (sel)
      core_pkg::FWD_EX_MEM: return ex_mem;
      core_pkg::FWD_MEM_WB: return mem_wb;
      default:              return own;
    endcase
  endfunction

  // --------------------
  // operands, corrected by the producers still in flight
  assign rs1_data_o = fwd_mux(fwd_a_i, rs1_q, fwd_ex_mem_i, fwd_mem_wb_i);
  assign rs2_data_o = fwd_mux(fwd_b_i, rs2_q, fwd_ex_mem_i, fwd_mem_wb_i);

  // on a hold the forwarded operand is written back, the producer moves on
  always_ff @(posedge clk) begin
    if (stall_i) begin
      rs1_q <= rs1_data_o;
      rs2_q <= rs2_data_o;
    end else begin
      rs1_q     <= id_ex.rs1_data;
      rs2_q     <= id_ex.rs2_data;
      pc_o      <= id_ex.pc;
      imm_o     <= id_ex.imm;
      rd_o      <= id_ex.rd;
      rs1_o     <= id_ex.rs1;
      rs2_o     <= id_ex.rs2;
      alu_op_o  <= id_ex.alu_op;
      opa_sel_o <= id_ex.opa_sel;
      imm_sel_o <= id_ex.imm_sel;
    end
  end

  // --------------------
  // side effects, a clear turns the slot into a bubble
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      write_en_o <= 1'b0;
      load_o     <= 1'b0;
      store_o    <= 1'b0;
    end else if (clear_i) begin
      write_en_o <= 1'b0;
      load_o     <= 1'b0;
      store_o    <= 1'b0;
    end else if (!stall_i) begin
      write_en_o <= id_ex.write_en;
      load_o     <= id_ex.load;
      store_o    <= id_ex.store;
    end
  end

endmodule

//--- src/isa_pkg.sv
package isa_pkg;

  // --------------------
  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // funct3 of the ALU operations, shared by register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 value that turns ADD into SUB
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // --------------------
  // field positions, lowest bit of each field
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

endpackage

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage #(
  parameter int DMEM_WORDS = 16
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  core_pkg::word_t    alu_result_i,
  input  core_pkg::word_t    store_data_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               write_en_i,
  input  logic               load_i,
  input  logic               store_i,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::word_t    wb_data_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  core_pkg::word_t dmem [DMEM_WORDS];
  logic [AW-1:0]   word_addr;
  core_pkg::word_t result;
  logic            write_en_q;

  // word aligned, the address wraps at the memory depth
  assign word_addr = alu_result_i[2 +: AW];

  // --------------------
  // data memory
  always_ff @(posedge clk) begin
    if (store_i) begin
      dmem[word_addr] <= store_data_i;
    end
  end

  assign result = load_i ? dmem[word_addr] : alu_result_i;

  // --------------------
  // MEM/WB register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      write_en_q <= 1'b0;
    end else begin
      write_en_q <= write_en_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= rd_i;
    wb_data_o <= result;
  end

  // x0 is never written, so it never shows on the port
  assign wb_valid_o = write_en_q & (wb_rd_o != '0);

endmodule
